// ==== logic/rv_core_pkg.sv ====
// Shared enums and instruction-field constants for the RV64I core, referenced by scoped names
package rv_core_pkg;

  localparam int XLEN = 64;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_IMM32  = 7'b0011011,
    OP_REG    = 7'b0110011,
    OP_REG32  = 7'b0111011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_SLTU, ALU_SLL, ALU_COPY_B} alu_op_e;

  typedef enum logic [2:0] {BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLTU, BR_BGEU} branch_op_e;

  typedef enum logic {A_RS1, A_PC} a_src_e;

  typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_src_e;

  // funct3 / funct7 values
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [6:0] F7_ZERO = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // inst[31:7] of ebreak
  localparam logic [24:0] EBREAK_HI = 25'h0002000;

endpackage

// ==== logic/decode_if.sv ====
// Decoded control bundle passed from the instruction decoder to the execute unit
`timescale 1ns/1ps

interface decode_if;

  logic                         valid;
  logic [rv_core_pkg::XLEN-1:0] pc;
  logic [4:0]                   ra;
  logic [4:0]                   rb;
  logic [4:0]                   rd;
  logic [rv_core_pkg::XLEN-1:0] imm;
  rv_core_pkg::alu_op_e         alu_op;
  rv_core_pkg::a_src_e          a_src;
  rv_core_pkg::b_src_e          b_src;
  rv_core_pkg::branch_op_e      branch_op;
  logic                         word_cut;
  logic                         reg_wr;
  logic                         halt;
  logic                         illegal;

  modport dec (output valid, pc, ra, rb, rd, imm, alu_op, a_src, b_src, branch_op,
               word_cut, reg_wr, halt, illegal);

  modport exe (input valid, pc, ra, rb, rd, imm, alu_op, a_src, b_src, branch_op,
               word_cut, reg_wr, halt, illegal);

endinterface

// ==== logic/result_if.sv ====
// One executed instruction handed from the execute unit to the writeback stage
`timescale 1ns/1ps

interface result_if;

  logic                         valid;
  logic [rv_core_pkg::XLEN-1:0] pc;
  logic [4:0]                   rd;
  logic                         we;
  logic [rv_core_pkg::XLEN-1:0] data;
  logic                         illegal;
  logic                         halt;

  modport exe (output valid, pc, rd, we, data, illegal, halt);

  modport wb (input valid, pc, rd, we, data, illegal, halt);

endinterface

// ==== logic/fetch_stage.sv ====
// Input stage holding the PC and the fetch register loaded on each accepted instruction strobe
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [63:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  input  logic [63:0] i_next_pc,
  input  logic        i_halted,
  output logic [31:0] o_inst,
  output logic [63:0] o_pc,
  output logic        o_valid,
  output logic [63:0] o_fetch_pc
);

  logic [63:0] pc_q;
  logic        advance;

  // An instruction in flight hands its next PC forward
  assign advance = o_valid & ~i_halted;
  assign o_pc    = advance ? i_next_pc : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q    <= RESET_PC;
      o_valid <= 1'b0;
    end else begin
      if (advance) begin
        pc_q <= i_next_pc;
      end
      o_valid <= i_inst_valid & ~i_halted;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      o_inst     <= i_inst;
      o_fetch_pc <= o_pc;
    end
  end

endmodule

// ==== logic/inst_decoder.sv ====
// Combinational decoder for the RV64I subset, producing operands, immediate and control
`timescale 1ns/1ps

module inst_decoder (
  input  logic                         i_valid,
  input  logic [rv_core_pkg::XLEN-1:0] i_pc,
  input  logic [31:0]                  i_inst,
  decode_if.dec                        o_dec
);

  rv_core_pkg::opcode_e         opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [rv_core_pkg::XLEN-1:0] imm_i;
  logic [rv_core_pkg::XLEN-1:0] imm_u;
  logic [rv_core_pkg::XLEN-1:0] imm_b;
  logic [rv_core_pkg::XLEN-1:0] imm_j;

  assign opcode = rv_core_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // Sign-extended immediates
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign o_dec.valid = i_valid;
  assign o_dec.pc    = i_pc;
  assign o_dec.ra    = i_inst[19:15];
  assign o_dec.rb    = i_inst[24:20];
  assign o_dec.rd    = i_inst[11:7];

  always_comb begin
    o_dec.imm       = imm_i;
    o_dec.alu_op    = rv_core_pkg::ALU_ADD;
    o_dec.a_src     = rv_core_pkg::A_RS1;
    o_dec.b_src     = rv_core_pkg::B_IMM;
    o_dec.branch_op = rv_core_pkg::BR_NONE;
    o_dec.word_cut  = 1'b0;
    o_dec.reg_wr    = 1'b0;
    o_dec.halt      = 1'b0;
    o_dec.illegal   = 1'b0;
    case (opcode)
      rv_core_pkg::OP_LUI: begin
        o_dec.imm    = imm_u;
        o_dec.alu_op = rv_core_pkg::ALU_COPY_B;
        o_dec.reg_wr = 1'b1;
      end
      rv_core_pkg::OP_AUIPC: begin
        o_dec.imm    = imm_u;
        o_dec.a_src  = rv_core_pkg::A_PC;
        o_dec.reg_wr = 1'b1;
      end
      rv_core_pkg::OP_JAL: begin
        o_dec.imm       = imm_j;
        o_dec.a_src     = rv_core_pkg::A_PC;
        o_dec.b_src     = rv_core_pkg::B_FOUR;
        o_dec.branch_op = rv_core_pkg::BR_JAL;
        o_dec.reg_wr    = 1'b1;
      end
      rv_core_pkg::OP_JALR: begin
        o_dec.a_src     = rv_core_pkg::A_PC;
        o_dec.b_src     = rv_core_pkg::B_FOUR;
        o_dec.branch_op = rv_core_pkg::BR_JALR;
        o_dec.reg_wr    = (funct3 == rv_core_pkg::F3_ADD);
        o_dec.illegal   = (funct3 != rv_core_pkg::F3_ADD);
      end
      rv_core_pkg::OP_BRANCH: begin
        o_dec.imm = imm_b;
        case (funct3)
          rv_core_pkg::F3_BEQ:  o_dec.branch_op = rv_core_pkg::BR_BEQ;
          rv_core_pkg::F3_BNE:  o_dec.branch_op = rv_core_pkg::BR_BNE;
          rv_core_pkg::F3_BLTU: o_dec.branch_op = rv_core_pkg::BR_BLTU;
          rv_core_pkg::F3_BGEU: o_dec.branch_op = rv_core_pkg::BR_BGEU;
          default:              o_dec.illegal   = 1'b1;
        endcase
      end
      rv_core_pkg::OP_IMM: begin
        case (funct3)
          rv_core_pkg::F3_ADD: o_dec.reg_wr = 1'b1;
          rv_core_pkg::F3_SLTU: begin
            o_dec.alu_op = rv_core_pkg::ALU_SLTU;
            o_dec.reg_wr = 1'b1;
          end
          rv_core_pkg::F3_SLL: begin
            // RV64 shamt is 6 bits wide
            o_dec.alu_op  = rv_core_pkg::ALU_SLL;
            o_dec.reg_wr  = (funct7[6:1] == 6'b0);
            o_dec.illegal = (funct7[6:1] != 6'b0);
          end
          default: o_dec.illegal = 1'b1;
        endcase
      end
      rv_core_pkg::OP_IMM32: begin
        o_dec.word_cut = 1'b1;
        o_dec.reg_wr   = (funct3 == rv_core_pkg::F3_ADD);
        o_dec.illegal  = (funct3 != rv_core_pkg::F3_ADD);
      end
      rv_core_pkg::OP_REG: begin
        o_dec.b_src = rv_core_pkg::B_RS2;
        if (funct3 == rv_core_pkg::F3_ADD && funct7 == rv_core_pkg::F7_ZERO) begin
          o_dec.reg_wr = 1'b1;
        end else if (funct3 == rv_core_pkg::F3_ADD && funct7 == rv_core_pkg::F7_SUB) begin
          o_dec.alu_op = rv_core_pkg::ALU_SUB;
          o_dec.reg_wr = 1'b1;
        end else begin
          o_dec.illegal = 1'b1;
        end
      end
      rv_core_pkg::OP_REG32: begin
        o_dec.b_src    = rv_core_pkg::B_RS2;
        o_dec.word_cut = 1'b1;
        o_dec.reg_wr   = (funct3 == rv_core_pkg::F3_ADD) && (funct7 == rv_core_pkg::F7_ZERO);
        o_dec.illegal  = !((funct3 == rv_core_pkg::F3_ADD) && (funct7 == rv_core_pkg::F7_ZERO));
      end
      rv_core_pkg::OP_SYSTEM: begin
        // Only ebreak is decoded here
        o_dec.halt    = (i_inst[31:7] == rv_core_pkg::EBREAK_HI);
        o_dec.illegal = (i_inst[31:7] != rv_core_pkg::EBREAK_HI);
      end
      default: o_dec.illegal = 1'b1;
    endcase
  end

endmodule

// ==== logic/reg_file.sv ====
// Integer register file with two asynchronous read ports and one synchronous write port
`timescale 1ns/1ps

module reg_file #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [4:0]      i_ra,
  input  logic [4:0]      i_rb,
  input  logic            i_we,
  input  logic [4:0]      i_wa,
  input  logic [XLEN-1:0] i_wd,
  output logic [XLEN-1:0] o_rs1,
  output logic [XLEN-1:0] o_rs2
);

  logic [XLEN-1:0] regs [32];

  // x0 always reads zero
  assign o_rs1 = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rs2 = (i_rb == 5'd0) ? '0 : regs[i_rb];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_wa != 5'd0) begin
      regs[i_wa] <= i_wd;
    end
  end

endmodule

// ==== logic/exec_unit.sv ====
// Execute stage computing the ALU result, branch decision and next PC of one instruction
`timescale 1ns/1ps

module exec_unit (
  decode_if.exe                        i_dec,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs1,
  input  logic [rv_core_pkg::XLEN-1:0] i_rs2,
  output logic [rv_core_pkg::XLEN-1:0] o_next_pc,
  result_if.exe                        o_res
);

  logic [rv_core_pkg::XLEN-1:0] op_a;
  logic [rv_core_pkg::XLEN-1:0] op_b;
  logic [rv_core_pkg::XLEN-1:0] alu_out;
  logic [rv_core_pkg::XLEN-1:0] pc_target;
  logic [rv_core_pkg::XLEN-1:0] jalr_target;
  logic                         taken;

  assign op_a = (i_dec.a_src == rv_core_pkg::A_PC) ? i_dec.pc : i_rs1;

  always_comb begin
    case (i_dec.b_src)
      rv_core_pkg::B_RS2:  op_b = i_rs2;
      rv_core_pkg::B_FOUR: op_b = 64'd4;
      default:             op_b = i_dec.imm;
    endcase
  end

  always_comb begin
    case (i_dec.alu_op)
      rv_core_pkg::ALU_SUB:    alu_out = op_a - op_b;
      rv_core_pkg::ALU_SLTU:   alu_out = {63'b0, op_a < op_b};
      rv_core_pkg::ALU_SLL:    alu_out = op_a << op_b[5:0];
      rv_core_pkg::ALU_COPY_B: alu_out = op_b;
      default:                 alu_out = op_a + op_b;
    endcase
  end

  assign pc_target   = i_dec.pc + i_dec.imm;
  assign jalr_target = (i_rs1 + i_dec.imm) & ~64'd1;

  always_comb begin
    case (i_dec.branch_op)
      rv_core_pkg::BR_JAL,
      rv_core_pkg::BR_JALR: taken = 1'b1;
      rv_core_pkg::BR_BEQ:  taken = (i_rs1 == i_rs2);
      rv_core_pkg::BR_BNE:  taken = (i_rs1 != i_rs2);
      rv_core_pkg::BR_BLTU: taken = (i_rs1 < i_rs2);
      rv_core_pkg::BR_BGEU: taken = (i_rs1 >= i_rs2);
      default:              taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_dec.branch_op == rv_core_pkg::BR_JALR) begin
      o_next_pc = jalr_target;
    end else if (taken) begin
      o_next_pc = pc_target;
    end else begin
      o_next_pc = i_dec.pc + 64'd4;
    end
  end

  assign o_res.valid   = i_dec.valid;
  assign o_res.pc      = i_dec.pc;
  assign o_res.rd      = i_dec.rd;
  assign o_res.we      = i_dec.reg_wr & (i_dec.rd != 5'd0);
  assign o_res.data    = i_dec.word_cut ? {{32{alu_out[31]}}, alu_out[31:0]} : alu_out;
  assign o_res.illegal = i_dec.illegal;
  assign o_res.halt    = i_dec.halt;

endmodule

// ==== logic/writeback.sv ====
// Writeback stage that retires results, drives the register-file write and keeps the halt state
`timescale 1ns/1ps

module writeback (
  input  logic                         i_clk,
  input  logic                         i_rst,
  result_if.wb                         i_res,
  output logic                         o_rf_we,
  output logic [4:0]                   o_rf_wa,
  output logic [rv_core_pkg::XLEN-1:0] o_rf_wd,
  output logic                         o_halted,
  output logic                         o_wb_valid,
  output logic [rv_core_pkg::XLEN-1:0] o_wb_pc,
  output logic [4:0]                   o_wb_rd,
  output logic                         o_wb_we,
  output logic [rv_core_pkg::XLEN-1:0] o_wb_data,
  output logic                         o_illegal
);

  logic retire;

  // Anything still in flight after ebreak is squashed
  assign retire  = i_res.valid & ~o_halted;
  assign o_rf_we = retire & i_res.we;
  assign o_rf_wa = i_res.rd;
  assign o_rf_wd = i_res.data;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
      o_illegal  <= 1'b0;
      o_halted   <= 1'b0;
    end else begin
      o_wb_valid <= retire;
      o_wb_we    <= o_rf_we;
      o_illegal  <= retire & i_res.illegal;
      o_halted   <= o_halted | (retire & i_res.halt);
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_pc   <= i_res.pc;
    o_wb_rd   <= i_res.rd;
    o_wb_data <= i_res.data;
  end

endmodule

// ==== logic/rv_core_top.sv ====
// Top level of the in-order RV64I core, fed one instruction per strobe and reporting each retire
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [63:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic [63:0] o_pc,
  output logic        o_wb_valid,
  output logic [63:0] o_wb_pc,
  output logic [4:0]  o_wb_rd,
  output logic        o_wb_we,
  output logic [63:0] o_wb_data,
  output logic        o_illegal,
  output logic        o_halt
);

  logic [31:0] f_inst;
  logic [63:0] f_pc;
  logic        f_valid;
  logic [63:0] next_pc;
  logic [63:0] rs1;
  logic [63:0] rs2;
  logic        rf_we;
  logic [4:0]  rf_wa;
  logic [63:0] rf_wd;

  decode_if dec_bus ();
  result_if res_bus ();

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_inst_valid(i_inst_valid),
    .i_inst      (i_inst),
    .i_next_pc   (next_pc),
    .i_halted    (o_halt),
    .o_inst      (f_inst),
    .o_pc        (o_pc),
    .o_valid     (f_valid),
    .o_fetch_pc  (f_pc)
  );

  inst_decoder u_dec (
    .i_valid(f_valid),
    .i_pc   (f_pc),
    .i_inst (f_inst),
    .o_dec  (dec_bus.dec)
  );

  reg_file #(
    .XLEN(rv_core_pkg::XLEN)
  ) u_rf (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_ra (dec_bus.ra),
    .i_rb (dec_bus.rb),
    .i_we (rf_we),
    .i_wa (rf_wa),
    .i_wd (rf_wd),
    .o_rs1(rs1),
    .o_rs2(rs2)
  );

  exec_unit u_exe (
    .i_dec    (dec_bus.exe),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .o_next_pc(next_pc),
    .o_res    (res_bus.exe)
  );

  writeback u_wb (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_res     (res_bus.wb),
    .o_rf_we   (rf_we),
    .o_rf_wa   (rf_wa),
    .o_rf_wd   (rf_wd),
    .o_halted  (o_halt),
    .o_wb_valid(o_wb_valid),
    .o_wb_pc   (o_wb_pc),
    .o_wb_rd   (o_wb_rd),
    .o_wb_we   (o_wb_we),
    .o_wb_data (o_wb_data),
    .o_illegal (o_illegal)
  );

endmodule

// ==== sim/rv_core_asserts.sv ====
// Concurrent checks on the retire ports of the core, attached to rv_core_top by bind
`timescale 1ns/1ps

module rv_core_asserts (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_wb_valid,
  input logic       i_wb_we,
  input logic [4:0] i_wb_rd,
  input logic       i_illegal,
  input logic       i_halt
);

  // Illegal flag only on a retire
  illegal_on_retire: assert property (@(posedge i_clk) disable iff (i_rst)
    i_illegal |-> i_wb_valid)
    else $error("o_illegal high without o_wb_valid");

  // x0 is never reported as written
  no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_wb_we && i_wb_rd == 5'd0))
    else $error("o_wb_we high with o_wb_rd equal to 0");

  // Nothing retires once halted
  quiet_after_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    i_halt |=> !i_wb_valid)
    else $error("o_wb_valid seen after o_halt");

endmodule

// ==== sim/tb_rv_core.sv ====
// Directed testbench for rv_core_top; run through filelist.f with tb_rv_core as top module
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          CLK_PERIOD     = 4;
  localparam logic [63:0] RESET_PC       = 64'h0000_0000_8000_0000;
  localparam int          NUM_INSTS      = 50;
  localparam int          TIMEOUT_CYCLES = NUM_INSTS * 10 + 10;

  typedef enum {
    K_LUI, K_AUIPC, K_JAL, K_JALR, K_BEQ, K_BNE, K_BLTU, K_BGEU, K_ADDI,
    K_SLTIU, K_SLLI, K_ADD, K_SUB, K_ADDIW, K_ADDW, K_EBREAK, K_ILLEGAL
  } inst_kind_e;

  typedef struct packed {
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [63:0] data;
    logic        illegal;
    logic        halt;
    int          cycle;
  } retire_t;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [63:0] o_pc;
  logic        o_wb_valid;
  logic [63:0] o_wb_pc;
  logic [4:0]  o_wb_rd;
  logic        o_wb_we;
  logic [63:0] o_wb_data;
  logic        o_illegal;
  logic        o_halt;

  // Architectural model of the core
  logic [63:0] shadow [32];
  logic [63:0] model_pc;
  retire_t     exp_list [$];
  int          retired = 0;
  int          cycle = 0;
  int          seed;

  rv_core_top #(
    .RESET_PC(RESET_PC)
  ) dut0 (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_inst_valid(inst_valid),
    .i_inst      (inst),
    .o_pc        (o_pc),
    .o_wb_valid  (o_wb_valid),
    .o_wb_pc     (o_wb_pc),
    .o_wb_rd     (o_wb_rd),
    .o_wb_we     (o_wb_we),
    .o_wb_data   (o_wb_data),
    .o_illegal   (o_illegal),
    .o_halt      (o_halt)
  );

  bind rv_core_top rv_core_asserts u_asserts (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_wb_valid(o_wb_valid),
    .i_wb_we   (o_wb_we),
    .i_wb_rd   (o_wb_rd),
    .i_illegal (o_illegal),
    .i_halt    (o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic stop_with_failure(string reason);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_with_failure("A checked value did not match its expected value");
    end
  endtask

  // Standard RV64I encodings
  function automatic logic [31:0] encode(inst_kind_e kind, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2, logic [20:0] imm);
    logic [2:0] f3;
    case (kind)
      K_BNE:   f3 = 3'b001;
      K_BLTU:  f3 = 3'b110;
      K_BGEU:  f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    case (kind)
      K_LUI:    return {imm[19:0], rd, 7'b0110111};
      K_AUIPC:  return {imm[19:0], rd, 7'b0010111};
      K_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
      K_JALR:   return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
      K_BEQ, K_BNE, K_BLTU, K_BGEU:
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
      K_ADDI:   return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      K_SLTIU:  return {imm[11:0], rs1, 3'b011, rd, 7'b0010011};
      K_SLLI:   return {6'b000000, imm[5:0], rs1, 3'b001, rd, 7'b0010011};
      K_ADD:    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_SUB:    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_ADDIW:  return {imm[11:0], rs1, 3'b000, rd, 7'b0011011};
      K_ADDW:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0111011};
      K_EBREAK: return 32'h0010_0073;
      default:  return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};  // ld, not supported
    endcase
  endfunction

  // Drives one strobe and queues the retire the model predicts
  task automatic issue(inst_kind_e kind, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                       logic [20:0] imm);
    retire_t     item;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [63:0] sum;
    logic [63:0] next_pc;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic        writes;
    logic        taken;
    check_value("o_pc", o_pc, model_pc);
    inst       = encode(kind, rd, rs1, rs2, imm);
    inst_valid = 1'b1;
    a       = shadow[rs1];
    b       = shadow[rs2];
    imm_i   = {{52{imm[11]}}, imm[11:0]};
    imm_u   = {{32{imm[19]}}, imm[19:0], 12'h000};
    imm_b   = {{51{imm[12]}}, imm[12:1], 1'b0};
    imm_j   = {{43{imm[20]}}, imm[20:1], 1'b0};
    next_pc = model_pc + 64'd4;
    writes  = 1'b1;
    res     = '0;
    case (kind)
      K_LUI:   res = imm_u;
      K_AUIPC: res = model_pc + imm_u;
      K_JAL: begin
        res     = model_pc + 64'd4;
        next_pc = model_pc + imm_j;
      end
      K_JALR: begin
        res     = model_pc + 64'd4;
        next_pc = (a + imm_i) & ~64'd1;
      end
      K_ADDI:  res = a + imm_i;
      K_SLTIU: res = (a < imm_i) ? 64'd1 : 64'd0;
      K_SLLI:  res = a << imm[5:0];
      K_ADD:   res = a + b;
      K_SUB:   res = a - b;
      K_ADDIW: begin
        sum = a + imm_i;
        res = {{32{sum[31]}}, sum[31:0]};
      end
      K_ADDW: begin
        sum = a + b;
        res = {{32{sum[31]}}, sum[31:0]};
      end
      default: writes = 1'b0;
    endcase
    taken = (kind == K_BEQ && a == b) || (kind == K_BNE && a != b) ||
            (kind == K_BLTU && a < b) || (kind == K_BGEU && a >= b);
    if (taken) begin
      next_pc = model_pc + imm_b;
    end
    item.pc      = model_pc;
    item.rd      = rd;
    item.we      = writes && (rd != 5'd0);
    item.data    = res;
    item.illegal = (kind == K_ILLEGAL);
    item.halt    = (kind == K_EBREAK);
    item.cycle   = cycle;
    exp_list.push_back(item);
    if (item.we) begin
      shadow[rd] = res;
    end
    model_pc = next_pc;
    @(negedge clk);
    inst_valid = 1'b0;
    check_value("o_pc", o_pc, model_pc);
  endtask

  // Strobe that a halted core must ignore
  task automatic issue_dropped(logic [31:0] code);
    check_value("o_pc", o_pc, model_pc);
    inst       = code;
    inst_valid = 1'b1;
    @(negedge clk);
    inst_valid = 1'b0;
    check_value("o_pc", o_pc, model_pc);
    // A retire of this strobe would show from the next cycle on
    @(negedge clk);
    repeat (4) begin
      check_value("o_wb_valid", 64'(o_wb_valid), 64'd0);
      check_value("o_pc", o_pc, model_pc);
      @(negedge clk);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 10) begin
        stop_with_failure("Timed out waiting for o_wb_valid of an issued instruction");
      end
    end while (retired != exp_list.size());
    @(negedge clk);
  endtask

  // Compares each retire with the oldest prediction
  always @(negedge clk) begin : retire_monitor
    retire_t exp_item;
    if (!rst && o_wb_valid) begin
      if (retired >= exp_list.size()) begin
        stop_with_failure("o_wb_valid seen with no instruction in flight");
      end else begin
        exp_item = exp_list[retired];
        retired  = retired + 1;
        check_value("o_wb_pc", o_wb_pc, exp_item.pc);
        check_value("retire latency", 64'(cycle - exp_item.cycle), 64'd2);
        check_value("o_illegal", 64'(o_illegal), 64'(exp_item.illegal));
        check_value("o_wb_we", 64'(o_wb_we), 64'(exp_item.we));
        check_value("o_halt", 64'(o_halt), 64'(exp_item.halt));
        if (exp_item.we) begin
          check_value("o_wb_rd", 64'(o_wb_rd), 64'(exp_item.rd));
          check_value("o_wb_data", o_wb_data, exp_item.data);
        end
      end
    end
  end

  task automatic test_reset();
    check_value("o_wb_valid", 64'(o_wb_valid), 64'd0);
    check_value("o_wb_we", 64'(o_wb_we), 64'd0);
    check_value("o_illegal", 64'(o_illegal), 64'd0);
    check_value("o_halt", 64'(o_halt), 64'd0);
    check_value("o_pc", o_pc, RESET_PC);
    issue(K_ADDI, 5'd1, 5'd0, 5'd0, 21'd5);
    drain();
  endtask

  task automatic test_arith();
    logic [31:0] rnd;
    // Dependent addi chain through x1..x7
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      issue(K_ADDI, 5'(i + 2), 5'(i + 1), 5'd0, 21'(rnd[11:0]));
    end
    rnd = $random(seed);
    issue(K_LUI, 5'd8, 5'd0, 5'd0, 21'(rnd[19:0]));
    issue(K_ADD, 5'd9, 5'd8, 5'd2, 21'd0);
    issue(K_SUB, 5'd10, 5'd9, 5'd7, 21'd0);
    rnd = $random(seed);
    issue(K_SLTIU, 5'd11, 5'd10, 5'd0, 21'(rnd[11:0]));
    issue(K_SLTIU, 5'd12, 5'd0, 5'd0, 21'd1);
    issue(K_SLLI, 5'd13, 5'd9, 5'd0, 21'd33);
    issue(K_SLLI, 5'd13, 5'd13, 5'd0, 21'd4);
    issue(K_ADDI, 5'd0, 5'd1, 5'd0, 21'd7);
    issue(K_ADD, 5'd0, 5'd9, 5'd10, 21'd0);
    drain();
  endtask

  task automatic test_word();
    issue(K_LUI, 5'd14, 5'd0, 5'd0, 21'h7ffff);
    issue(K_ADDI, 5'd14, 5'd14, 5'd0, 21'h7ff);
    issue(K_ADDIW, 5'd15, 5'd14, 5'd0, 21'h7ff);
    // Crosses 0x7fffffff
    issue(K_ADDIW, 5'd16, 5'd15, 5'd0, 21'd2);
    issue(K_ADDW, 5'd17, 5'd16, 5'd16, 21'd0);
    issue(K_ADDW, 5'd18, 5'd15, 5'd15, 21'd0);
    issue(K_ADDIW, 5'd19, 5'd0, 5'd0, 21'hfff);
    drain();
  endtask

  task automatic test_control();
    issue(K_ADDI, 5'd20, 5'd0, 5'd0, 21'd5);
    issue(K_ADDI, 5'd21, 5'd0, 5'd0, 21'd9);
    issue(K_ADDI, 5'd22, 5'd0, 5'd0, 21'hfff);
    issue(K_BEQ, 5'd0, 5'd20, 5'd20, 21'h8);
    issue(K_BEQ, 5'd0, 5'd20, 5'd21, 21'h8);
    issue(K_BNE, 5'd0, 5'd20, 5'd21, 21'hc);
    issue(K_BNE, 5'd0, 5'd20, 5'd20, 21'hc);
    issue(K_BLTU, 5'd0, 5'd20, 5'd22, 21'h10);
    issue(K_BLTU, 5'd0, 5'd22, 5'd20, 21'h10);
    issue(K_BGEU, 5'd0, 5'd22, 5'd20, 21'h01ff8);
    issue(K_BGEU, 5'd0, 5'd20, 5'd21, 21'h20);
    issue(K_JAL, 5'd23, 5'd0, 5'd0, 21'h40);
    issue(K_JAL, 5'd0, 5'd0, 5'd0, 21'h1ffff0);
    issue(K_AUIPC, 5'd25, 5'd0, 5'd0, 21'd0);
    // Odd target, bit 0 must clear
    issue(K_JALR, 5'd26, 5'd25, 5'd0, 21'h21);
    issue(K_AUIPC, 5'd27, 5'd0, 5'd0, 21'h12345);
    issue(K_AUIPC, 5'd28, 5'd0, 5'd0, 21'hfffff);
    drain();
  endtask

  task automatic test_illegal();
    issue(K_ILLEGAL, 5'd5, 5'd1, 5'd0, 21'd0);
    issue(K_ADD, 5'd29, 5'd5, 5'd0, 21'd0);
    drain();
  endtask

  task automatic test_halt();
    issue(K_EBREAK, 5'd0, 5'd0, 5'd0, 21'd0);
    // Back to back with ebreak, then long after it
    issue_dropped(encode(K_ADDI, 5'd3, 5'd0, 5'd0, 21'd1));
    drain();
    check_value("o_halt", 64'(o_halt), 64'd1);
    issue_dropped(encode(K_ADD, 5'd4, 5'd1, 5'd2, 21'd0));
  endtask

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    seed       = 91;
    model_pc   = RESET_PC;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_arith();
    test_word();
    test_control();
    test_illegal();
    test_halt();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    stop_with_failure("Run timed out before all tests finished");
  end

endmodule

// ==== filelist.f ====
logic/rv_core_pkg.sv
logic/decode_if.sv
logic/result_if.sv
logic/fetch_stage.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/writeback.sv
logic/rv_core_top.sv
sim/rv_core_asserts.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status reports pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_rv_core \
  -Mdir obj_dir -o tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit "$status"
fi

exit 0
